/* compile.f */
+incdir+include
src/exu_pkg.sv
src/alu.sv
src/exu.sv
src/lsu.sv
src/csr_file.sv
src/exec_top.sv
verification/tb_clock.sv
verification/exec_tb.sv

/* verification/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_tb import exu_pkg::*; ();

  // about 105 instructions at 2 to 4 cycles each, near 350 cycles
  localparam int max_cycles = 2000;

  logic        clk;
  logic        rstn;
  logic        id_valid;
  logic        id_ready;
  logic [31:0] pc, src1, src2, imm, alu_a, alu_b;
  opcode_e     opcode;
  logic [2:0]  funct;
  logic [4:0]  rd;
  alu_op_e     alu_funct;
  logic        alu_funcs;
  logic [31:0] npc;
  logic        npc_valid;
  logic        gpr_wen;
  logic [4:0]  gpr_waddr;
  logic [31:0] gpr_wdata;

  // results of the last instruction
  logic [31:0] got_npc, got_wdata;
  logic [4:0]  got_waddr;
  logic        got_wen, got_busy;

  logic [31:0] mem_model [mem_words];
  int          cycles = 0;

  tb_clock u_clock (.clk(clk));

  exec_top UUT (
    .clk       (clk),
    .rstn      (rstn),
    .id_valid  (id_valid),
    .id_ready  (id_ready),
    .pc        (pc),
    .opcode    (opcode),
    .funct     (funct),
    .rd        (rd),
    .src1      (src1),
    .src2      (src2),
    .imm       (imm),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_funct (alu_funct),
    .alu_funcs (alu_funcs),
    .npc       (npc),
    .npc_valid (npc_valid),
    .gpr_wen   (gpr_wen),
    .gpr_waddr (gpr_waddr),
    .gpr_wdata (gpr_wdata)
  );

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("ERROR: %s", what);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > max_cycles) begin
      $display("ERROR: DUT stopped responding, run exceeded %0d cycles", max_cycles);
      abort_run();
    end
  end

  // reference rules of the RV32I integer ops
  function automatic logic [31:0] alu_model(input logic [31:0] a, input logic [31:0] b,
                                            input alu_op_e op, input logic s);
    logic signed [31:0] sa;
    logic [4:0]         sh;
    sa = a;
    sh = b[4:0];
    case (op)
      alu_add:  return s ? a - b : a + b;
      alu_sll:  return a << sh;
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl: begin
        if (s) return sa >>> sh; // arithmetic
        else return a >> sh;
      end
      alu_or:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic [31:0] load_model(input logic [31:0] word, input logic [1:0] off,
                                             input mem_size_e sz);
    logic [31:0] lane;
    lane = word >> (8 * off);
    case (sz)
      mem_b:   return {{24{lane[7]}}, lane[7:0]};
      mem_bu:  return {24'd0, lane[7:0]};
      mem_h:   return {{16{lane[15]}}, lane[15:0]};
      mem_hu:  return {16'd0, lane[15:0]};
      default: return word;
    endcase
  endfunction

  // offer one instruction, wait for acceptance and for the stage to be free again
  task automatic issue(input opcode_e op, input logic [2:0] fn, input logic [4:0] rdi,
                       input logic [31:0] p, input logic [31:0] s1, input logic [31:0] s2,
                       input logic [31:0] im, input logic [31:0] a, input logic [31:0] b,
                       input alu_op_e af, input logic fs);
    @(posedge clk);
    id_valid  <= 1'b1;
    opcode    <= op;
    funct     <= fn;
    rd        <= rdi;
    pc        <= p;
    src1      <= s1;
    src2      <= s2;
    imm       <= im;
    alu_a     <= a;
    alu_b     <= b;
    alu_funct <= af;
    alu_funcs <= fs;
    @(negedge clk);
    while (!id_ready) @(negedge clk);
    confirm(npc_valid, "npc_valid is low while an instruction is offered");
    got_npc = npc;
    @(posedge clk); // accepted on this edge
    id_valid <= 1'b0;
    @(negedge clk);
    got_busy = !id_ready;
    while (!id_ready) begin
      confirm(!gpr_wen, "register write while a memory access is pending");
      @(negedge clk);
    end
    got_wen   = gpr_wen;
    got_waddr = gpr_waddr;
    got_wdata = gpr_wdata;
  endtask

  task automatic arith_writeback();
    logic [31:0] a, b;
    logic [4:0]  r;
    alu_op_e     op;
    for (int k = 0; k < 8; k++) begin
      for (int s = 0; s < 2; s++) begin
        a  = $urandom();
        b  = $urandom();
        r  = 5'($urandom_range(31, 1));
        op = alu_op_e'(k);
        issue(op_reg, 3'(k), r, 32'h100, a, b, 32'd0, a, b, op, s[0]);
        expect_eq("gpr_wen", got_wen, 1);
        expect_eq("gpr_waddr", got_waddr, r);
        expect_eq("gpr_wdata", got_wdata, alu_model(a, b, op, s[0]));
        expect_eq("npc", got_npc, 32'h104);
      end
    end
    issue(op_imm, 3'd0, 5'd0, 32'h200, 0, 0, 0, 32'h1234, 32'h1, alu_add, 1'b0); // x0
    expect_eq("gpr_wen", got_wen, 0);
  endtask

  task automatic next_pc_rules();
    logic [31:0] p, a, b, tmp, im, exp;
    logic        take;
    branch_e     br;
    alu_op_e     cmp;
    p  = $urandom() & ~32'h3;
    im = $urandom(); // odd offsets exercise the cleared bit 0
    issue(op_jal, 3'd0, 5'd1, p, 0, 0, im, p, 32'd4, alu_add, 1'b0);
    expect_eq("npc", got_npc, (p + im) & ~32'h1);
    expect_eq("gpr_wdata", got_wdata, p + 32'd4);
    a  = $urandom();
    im = $urandom();
    issue(op_jalr, 3'd0, 5'd2, p, a, 0, im, p, 32'd4, alu_add, 1'b0);
    expect_eq("npc", got_npc, (a + im) & ~32'h1);
    for (int k = 0; k < 6; k++) begin
      br = branch_e'((k < 2) ? k : k + 2);
      for (int t = 0; t < 3; t++) begin
        if (t == 0) begin
          a = $urandom();
          b = a;
        end else if (t == 1) begin
          a = $urandom();
          b = $urandom();
        end else begin
          tmp = a; // swapped pair flips the compare
          a   = b;
          b   = tmp;
        end
        case (br)
          br_beq:  take = a == b;
          br_bne:  take = a != b;
          br_blt:  take = $signed(a) < $signed(b);
          br_bge:  take = $signed(a) >= $signed(b);
          br_bltu: take = a < b;
          default: take = a >= b;
        endcase
        if (br inside {br_blt, br_bge}) cmp = alu_slt;
        else if (br inside {br_bltu, br_bgeu}) cmp = alu_sltu;
        else cmp = alu_add;
        im  = $urandom();
        exp = take ? p + im : p + 32'd4;
        issue(op_branch, br, 5'd3, p, a, b, im, a, b, cmp, br inside {br_beq, br_bne});
        expect_eq("npc", got_npc, exp & ~32'h1);
        expect_eq("gpr_wen", got_wen, 0);
      end
    end
  endtask

  task automatic store_and_track(input logic [31:0] addr, input logic [31:0] data,
                                 input mem_size_e sz);
    int idx;
    idx = (addr >> 2) % mem_words;
    issue(op_store, sz, 5'd7, 32'h400, 32'd0, data, 32'd0, addr, 32'd0, alu_add, 1'b0);
    confirm(got_busy, "id_ready stayed high during a store");
    expect_eq("gpr_wen", got_wen, 0);
    case (sz)
      mem_b:   mem_model[idx][8*addr[1:0] +: 8] = data[7:0];
      mem_h:   mem_model[idx][8*addr[1:0] +: 16] = data[15:0];
      default: mem_model[idx] = data;
    endcase
  endtask

  task automatic load_and_compare(input logic [31:0] addr, input mem_size_e sz);
    logic [4:0] r;
    int         idx;
    idx = (addr >> 2) % mem_words;
    r   = 5'($urandom_range(31, 1));
    issue(op_load, sz, r, 32'h480, 32'd0, 32'd0, 32'd0, addr, 32'd0, alu_add, 1'b0);
    confirm(got_busy, "id_ready stayed high during a load");
    expect_eq("gpr_wen", got_wen, 1);
    expect_eq("gpr_waddr", got_waddr, r);
    expect_eq("gpr_wdata", got_wdata, load_model(mem_model[idx], addr[1:0], sz));
  endtask

  task automatic store_then_load();
    int          words [4];
    mem_size_e   sizes [5];
    logic [31:0] addr;
    words = '{3, 64, 130, 255};
    sizes = '{mem_b, mem_h, mem_w, mem_bu, mem_hu};
    for (int i = 0; i < 4; i++) begin
      store_and_track(words[i] * 4, $urandom(), mem_w);
    end
    // partial writes on top of full words
    store_and_track(words[0] * 4 + 2, $urandom(), mem_h);
    store_and_track(words[1] * 4, $urandom(), mem_h);
    store_and_track(words[2] * 4 + 1, $urandom(), mem_b);
    store_and_track(words[3] * 4 + 3, $urandom(), mem_b);
    for (int i = 0; i < 4; i++) begin
      for (int off = 0; off < 4; off++) begin
        addr = words[i] * 4 + off;
        foreach (sizes[s]) begin
          if (sizes[s] == mem_w && off != 0) continue;
          if (sizes[s] inside {mem_h, mem_hu} && off[0]) continue;
          load_and_compare(addr, sizes[s]);
        end
      end
    end
  endtask

  task automatic csr_access(input csr_op_e op, input logic [11:0] addr, input logic [31:0] v);
    issue(op_system, op, 5'd5, 32'h800, v, 32'd0, {20'd0, addr}, 0, 0, alu_add, 1'b0);
    expect_eq("gpr_wen", got_wen, 1);
  endtask

  task automatic csr_read_modify();
    logic [31:0] model, v;
    csr_op_e     ops [3];
    ops   = '{csr_rw, csr_rs, csr_rc};
    model = 32'd0; // mtvec after reset
    for (int i = 0; i < 3; i++) begin
      v = $urandom();
      csr_access(ops[i], csr_mtvec, v);
      expect_eq("gpr_wdata", got_wdata, model);
      case (ops[i])
        csr_rw:  model = v;
        csr_rs:  model = model | v;
        default: model = model & ~v;
      endcase
    end
    csr_access(csr_rs, csr_mtvec, 32'd0); // read back only
    expect_eq("gpr_wdata", got_wdata, model);
  endtask

  task automatic ecall_mret();
    logic [31:0] tv, epc;
    tv  = $urandom() & ~32'h3;
    epc = $urandom() & ~32'h3;
    csr_access(csr_rw, csr_mtvec, tv);
    issue(op_system, csr_priv, 5'd0, epc, 0, 0, 32'd0, 0, 0, alu_add, 1'b0);
    expect_eq("npc", got_npc, tv);
    expect_eq("gpr_wen", got_wen, 0);
    issue(op_system, csr_priv, 5'd0, epc + 32'h40, 0, 0, {20'd0, imm_mret}, 0, 0,
          alu_add, 1'b0);
    expect_eq("npc", got_npc, epc); // mepc came from the ecall
    csr_access(csr_rs, csr_mcause, 32'd0);
    expect_eq("gpr_wdata", got_wdata, mcause_ecall);
  endtask

  initial begin
    void'($urandom(32'h6895));
    rstn      = 1'b1;
    id_valid  = 1'b0;
    pc        = 32'd0;
    opcode    = op_imm;
    funct     = 3'd0;
    rd        = 5'd0;
    src1      = 32'd0;
    src2      = 32'd0;
    imm       = 32'd0;
    alu_a     = 32'd0;
    alu_b     = 32'd0;
    alu_funct = alu_add;
    alu_funcs = 1'b0;
    repeat (16) @(posedge clk);
    rstn <= 1'b0;
    @(negedge clk);
    expect_eq("id_ready", id_ready, 1);
    expect_eq("gpr_wen", gpr_wen, 0);
    arith_writeback();
    next_pc_rules();
    store_then_load();
    csr_read_modify();
    ecall_mret();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int half_period = 5; // 10 ns period

  initial clk = 1'b0;

  always #half_period clk = ~clk;

endmodule

`default_nettype wire

/* src/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top import exu_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        id_valid,
  output logic        id_ready,
  input  logic [31:0] pc,
  input  opcode_e     opcode,
  input  logic [2:0]  funct,
  input  logic [4:0]  rd,
  input  logic [31:0] src1,
  input  logic [31:0] src2,
  input  logic [31:0] imm,
  input  logic [31:0] alu_a,
  input  logic [31:0] alu_b,
  input  alu_op_e     alu_funct,
  input  logic        alu_funcs,
  output logic [31:0] npc,
  output logic        npc_valid,
  output logic        gpr_wen,
  output logic [4:0]  gpr_waddr,
  output logic [31:0] gpr_wdata
);

  logic [11:0] csr_raddr;
  logic [31:0] csr_rdata;
  logic        csr_wen1, csr_wen2;
  logic [11:0] csr_waddr1, csr_waddr2;
  logic [31:0] csr_wdata1, csr_wdata2;

  // exu to lsu
  logic        req_valid, req_ready, req_write;
  mem_size_e   req_size;
  logic [31:0] req_addr, req_wdata;
  logic        resp_valid, resp_ready;
  logic [31:0] resp_rdata;

  exu u_exu (
    .clk        (clk),
    .rstn       (rstn),
    .id_valid   (id_valid),
    .id_ready   (id_ready),
    .pc         (pc),
    .opcode     (opcode),
    .funct      (funct),
    .rd         (rd),
    .src1       (src1),
    .src2       (src2),
    .imm        (imm),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_funct  (alu_funct),
    .alu_funcs  (alu_funcs),
    .npc        (npc),
    .npc_valid  (npc_valid),
    .gpr_wen    (gpr_wen),
    .gpr_waddr  (gpr_waddr),
    .gpr_wdata  (gpr_wdata),
    .csr_raddr  (csr_raddr),
    .csr_rdata  (csr_rdata),
    .csr_wen1   (csr_wen1),
    .csr_waddr1 (csr_waddr1),
    .csr_wdata1 (csr_wdata1),
    .csr_wen2   (csr_wen2),
    .csr_waddr2 (csr_waddr2),
    .csr_wdata2 (csr_wdata2),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_write  (req_write),
    .req_size   (req_size),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata)
  );

  lsu u_lsu (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_write  (req_write),
    .req_size   (req_size),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_ready (resp_ready)
  );

  csr_file u_csr_file (
    .clk        (clk),
    .rstn       (rstn),
    .csr_raddr  (csr_raddr),
    .csr_rdata  (csr_rdata),
    .csr_wen1   (csr_wen1),
    .csr_waddr1 (csr_waddr1),
    .csr_wdata1 (csr_wdata1),
    .csr_wen2   (csr_wen2),
    .csr_waddr2 (csr_waddr2),
    .csr_wdata2 (csr_wdata2)
  );

endmodule

`default_nettype wire

/* src/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file import exu_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic [11:0] csr_raddr,
  output logic [31:0] csr_rdata,
  input  logic        csr_wen1,
  input  logic [11:0] csr_waddr1,
  input  logic [31:0] csr_wdata1,
  input  logic        csr_wen2,
  input  logic [11:0] csr_waddr2,
  input  logic [31:0] csr_wdata2
);

  logic [31:0] regs [4]; // mstatus, mtvec, mepc, mcause
  logic [2:0]  rsel, wsel1, wsel2;

  // {hit, index}
  function automatic logic [2:0] csr_sel(input logic [11:0] addr);
    case (addr)
      csr_mstatus: return 3'b100;
      csr_mtvec:   return 3'b101;
      csr_mepc:    return 3'b110;
      csr_mcause:  return 3'b111;
      default:     return 3'b000;
    endcase
  endfunction

  assign rsel  = csr_sel(csr_raddr);
  assign wsel1 = csr_sel(csr_waddr1);
  assign wsel2 = csr_sel(csr_waddr2);

  assign csr_rdata = rsel[2] ? regs[rsel[1:0]] : 32'd0;

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= 32'd0;
      end
    end else begin
      if (csr_wen1 && wsel1[2]) regs[wsel1[1:0]] <= csr_wdata1;
      if (csr_wen2 && wsel2[2]) regs[wsel2[1:0]] <= csr_wdata2; // last one wins
    end
  end

  // exu only uses both ports for ecall
  a_no_same_addr: assert property (@(posedge clk) disable iff (rstn)
    !(csr_wen1 && csr_wen2 && (csr_waddr1 == csr_waddr2)));

endmodule

`default_nettype wire

/* src/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu import exu_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        req_valid,
  output logic        req_ready,
  input  logic        req_write,
  input  mem_size_e   req_size,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  output logic        resp_valid,
  output logic [31:0] resp_rdata,
  input  logic        resp_ready
);

  logic [31:0] mem [mem_words];
  logic        req_fire, resp_fire;
  logic [$clog2(mem_words)-1:0] idx;
  logic [3:0]  be;
  logic [31:0] wlane;
  logic [31:0] rword;
  logic [31:0] lane;
  logic [1:0]  off_q;
  mem_size_e   size_q;
  logic        write_q;

  assign req_fire  = req_valid && req_ready;
  assign resp_fire = resp_valid && resp_ready;
  assign idx       = req_addr[$clog2(mem_words)+1:2];

  // byte enables and replicated store data
  always_comb begin
    case (req_size)
      mem_b, mem_bu: begin
        be    = 4'b0001 << req_addr[1:0];
        wlane = {4{req_wdata[7:0]}};
      end
      mem_h, mem_hu: begin
        be    = 4'b0011 << req_addr[1:0];
        wlane = {2{req_wdata[15:0]}};
      end
      default: begin
        be    = 4'b1111;
        wlane = req_wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (req_write && be[i]) mem[idx][8*i +: 8] <= wlane[8*i +: 8];
      end
      rword   <= mem[idx];
      off_q   <= req_addr[1:0];
      size_q  <= req_size;
      write_q <= req_write;
    end
  end

  // req_ready stays low until the response leaves
  always_ff @(posedge clk) begin
    if (rstn) begin
      req_ready  <= 1'b1;
      resp_valid <= 1'b0;
    end else if (req_fire) begin
      req_ready  <= 1'b0;
      resp_valid <= 1'b1;
    end else if (resp_fire) begin
      req_ready  <= 1'b1;
      resp_valid <= 1'b0;
    end
  end

  assign lane = rword >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      mem_b:   resp_rdata = {{24{lane[7]}}, lane[7:0]};
      mem_bu:  resp_rdata = {24'd0, lane[7:0]};
      mem_h:   resp_rdata = {{16{lane[15]}}, lane[15:0]};
      mem_hu:  resp_rdata = {16'd0, lane[15:0]};
      default: resp_rdata = rword;
    endcase
    if (write_q) resp_rdata = 32'd0; // stores answer with zero
  end

  a_aligned: assert property (@(posedge clk) disable iff (rstn)
    req_valid |-> !((req_size inside {mem_h, mem_hu}) && req_addr[0])
              && !((req_size == mem_w) && (req_addr[1:0] != 2'b00)));

  a_resp_blocks_req: assert property (@(posedge clk) disable iff (rstn)
    resp_valid |-> !req_ready);

endmodule

`default_nettype wire

/* src/exu.sv */
`timescale 1ns/1ps
`default_nettype none

module exu import exu_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        id_valid,
  output logic        id_ready,
  input  logic [31:0] pc,
  input  opcode_e     opcode,
  input  logic [2:0]  funct,
  input  logic [4:0]  rd,
  input  logic [31:0] src1,
  input  logic [31:0] src2,
  input  logic [31:0] imm,
  input  logic [31:0] alu_a,
  input  logic [31:0] alu_b,
  input  alu_op_e     alu_funct,
  input  logic        alu_funcs,
  output logic [31:0] npc,
  output logic        npc_valid,
  output logic        gpr_wen,
  output logic [4:0]  gpr_waddr,
  output logic [31:0] gpr_wdata,
  output logic [11:0] csr_raddr,
  input  logic [31:0] csr_rdata,
  output logic        csr_wen1,
  output logic [11:0] csr_waddr1,
  output logic [31:0] csr_wdata1,
  output logic        csr_wen2,
  output logic [11:0] csr_waddr2,
  output logic [31:0] csr_wdata2,
  output logic        req_valid,
  input  logic        req_ready,
  output logic        req_write,
  output mem_size_e   req_size,
  output logic [31:0] req_addr,
  output logic [31:0] req_wdata,
  input  logic        resp_valid,
  output logic        resp_ready,
  input  logic [31:0] resp_rdata
);

  typedef enum logic [1:0] {st_idle, st_req, st_resp} ls_state_e;

  ls_state_e   state;
  logic [31:0] alu_res;
  logic        accept, req_fire, resp_fire;
  logic        is_sys, is_priv, is_ecall, is_mret, is_csr_op, is_mem;
  csr_op_e     csr_op;
  branch_e     br_op;
  logic        br_taken;
  logic        wb_en;
  logic [31:0] wb_data;
  logic [31:0] csr_old;
  logic [31:0] csr_new;
  logic [31:0] npc_raw;

  alu u_alu (
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_funct (alu_funct),
    .alu_funcs (alu_funcs),
    .result    (alu_res)
  );

  assign accept    = id_valid && id_ready;
  assign req_fire  = req_valid && req_ready;
  assign resp_fire = resp_valid && resp_ready;
  assign resp_ready = state == st_resp;
  assign npc_valid = accept;

  assign csr_op    = csr_op_e'(funct);
  assign br_op     = branch_e'(funct);
  assign is_mem    = (opcode == op_load) || (opcode == op_store);
  assign is_sys    = opcode == op_system;
  assign is_priv   = is_sys && (csr_op == csr_priv);
  assign is_ecall  = is_priv && (imm[11:0] == 12'h000);
  assign is_mret   = is_priv && (imm[11:0] == imm_mret);
  assign is_csr_op = is_sys && (csr_op inside {csr_rw, csr_rs, csr_rc});

  assign csr_raddr = is_ecall ? csr_mtvec : (is_mret ? csr_mepc : imm[11:0]);

  // bypass csr writes still in flight
  always_comb begin
    csr_old = csr_rdata;
    if (csr_wen1 && csr_waddr1 == csr_raddr) csr_old = csr_wdata1;
    if (csr_wen2 && csr_waddr2 == csr_raddr) csr_old = csr_wdata2; // port 2 wins
  end

  always_comb begin
    case (csr_op)
      csr_rs:  csr_new = csr_old | src1;
      csr_rc:  csr_new = csr_old & ~src1;
      default: csr_new = src1;
    endcase
  end

  always_comb begin
    wb_en   = 1'b0;
    wb_data = alu_res;
    case (opcode)
      op_lui, op_auipc, op_jal, op_jalr, op_imm, op_reg: wb_en = 1'b1;
      op_system: begin
        wb_en   = is_csr_op;
        wb_data = csr_old;
      end
      default: wb_en = 1'b0; // load data comes with the response
    endcase
  end

  always_comb begin
    case (br_op)
      br_beq:          br_taken = alu_res == 32'd0;
      br_bne:          br_taken = alu_res != 32'd0;
      br_blt, br_bltu: br_taken = alu_res[0];
      br_bge, br_bgeu: br_taken = !alu_res[0];
      default:         br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      op_jal:    npc_raw = pc + imm;
      op_jalr:   npc_raw = src1 + imm;
      op_branch: npc_raw = br_taken ? pc + imm : pc + 32'd4;
      op_system: npc_raw = (is_ecall || is_mret) ? csr_old : pc + 32'd4;
      default:   npc_raw = pc + 32'd4;
    endcase
  end

  assign npc = {npc_raw[31:1], 1'b0};

  // ecall cause goes out on port 2
  assign csr_waddr2 = csr_mcause;
  assign csr_wdata2 = mcause_ecall;

  always_ff @(posedge clk) begin
    if (rstn) begin
      state     <= st_idle;
      id_ready  <= 1'b1;
      req_valid <= 1'b0;
      gpr_wen   <= 1'b0;
      csr_wen1  <= 1'b0;
      csr_wen2  <= 1'b0;
    end else begin
      gpr_wen  <= 1'b0;
      csr_wen1 <= accept && (is_csr_op || is_ecall);
      csr_wen2 <= accept && is_ecall;
      case (state)
        st_idle: begin
          if (accept && is_mem) begin
            state     <= st_req;
            req_valid <= 1'b1;
            id_ready  <= 1'b0; // one access in flight
          end else if (accept) begin
            gpr_wen <= wb_en && (rd != 5'd0);
          end
        end
        st_req: begin
          if (req_fire) begin
            req_valid <= 1'b0;
            state     <= st_resp;
          end
        end
        st_resp: begin
          if (resp_fire) begin
            state    <= st_idle;
            id_ready <= 1'b1;
            gpr_wen  <= !req_write && (gpr_waddr != 5'd0);
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // gpr_waddr also holds rd for a pending load
  always_ff @(posedge clk) begin
    if (accept) begin
      gpr_waddr  <= rd;
      gpr_wdata  <= wb_data;
      csr_waddr1 <= is_ecall ? csr_mepc : imm[11:0];
      csr_wdata1 <= is_ecall ? pc : csr_new;
      req_write  <= opcode == op_store;
      req_size   <= mem_size_e'(funct);
      req_addr   <= alu_res;
      req_wdata  <= src2;
    end
    if (resp_fire) gpr_wdata <= resp_rdata;
  end

  // a write pulse lasts one cycle unless the next instruction is already taken
  a_gpr_wen_pulse: assert property (@(posedge clk) disable iff (rstn)
    gpr_wen && !accept |=> !gpr_wen);

  a_req_rise: assert property (@(posedge clk) disable iff (rstn)
    $rose(req_valid) |-> state == st_req);

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import exu_pkg::*; (
  input  logic [31:0] alu_a,
  input  logic [31:0] alu_b,
  input  alu_op_e     alu_funct,
  input  logic        alu_funcs,
  output logic [31:0] result
);

  logic [4:0]  shamt;
  logic [31:0] sum;
  logic [31:0] srl_res;
  logic [31:0] sra_res;

  assign shamt   = alu_b[4:0];
  assign sum     = alu_funcs ? alu_a - alu_b : alu_a + alu_b;
  assign srl_res = alu_a >> shamt;
  assign sra_res = $signed(alu_a) >>> shamt; // keep signed context

  always_comb begin
    case (alu_funct)
      alu_add:  result = sum;
      alu_sll:  result = alu_a << shamt;
      alu_slt:  result = {31'd0, $signed(alu_a) < $signed(alu_b)};
      alu_sltu: result = {31'd0, alu_a < alu_b};
      alu_xor:  result = alu_a ^ alu_b;
      alu_srl: begin
        if (alu_funcs) begin
          result = sra_res;
        end else begin
          result = srl_res;
        end
      end
      alu_or:   result = alu_a | alu_b;
      alu_and:  result = alu_a & alu_b;
      default:  result = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

/* src/exu_pkg.sv */
`default_nettype none

package exu_pkg;

  `include "exu_defs.svh"

  typedef enum logic [4:0] {
    op_lui    = `OPC_LUI,
    op_auipc  = `OPC_AUIPC,
    op_jal    = `OPC_JAL,
    op_jalr   = `OPC_JALR,
    op_branch = `OPC_BRANCH,
    op_load   = `OPC_LOAD,
    op_store  = `OPC_STORE,
    op_imm    = `OPC_IMM,
    op_reg    = `OPC_REG,
    op_system = `OPC_SYSTEM
  } opcode_e;

  typedef enum logic [2:0] {
    br_beq  = `BR_BEQ,
    br_bne  = `BR_BNE,
    br_blt  = `BR_BLT,
    br_bge  = `BR_BGE,
    br_bltu = `BR_BLTU,
    br_bgeu = `BR_BGEU
  } branch_e;

  // load/store funct3
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_bu = 3'b100,
    mem_hu = 3'b101
  } mem_size_e;

  typedef enum logic [2:0] {
    csr_priv = `CSROP_PRIV,
    csr_rw   = `CSROP_RW,
    csr_rs   = `CSROP_RS,
    csr_rc   = `CSROP_RC
  } csr_op_e;

  typedef enum logic [2:0] {
    alu_add  = 3'b000, // sub with alu_funcs
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101, // sra with alu_funcs
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_op_e;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  localparam logic [31:0] mcause_ecall = 32'd11; // environment call from m-mode
  localparam logic [11:0] imm_mret     = 12'h302;

  localparam int mem_words = 256;

endpackage

`default_nettype wire

/* include/exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// major opcodes, inst[6:2]
`define OPC_LUI     5'b01101
`define OPC_AUIPC   5'b00101
`define OPC_JAL     5'b11011
`define OPC_JALR    5'b11001
`define OPC_BRANCH  5'b11000
`define OPC_LOAD    5'b00000
`define OPC_STORE   5'b01000
`define OPC_IMM     5'b00100
`define OPC_REG     5'b01100
`define OPC_SYSTEM  5'b11100

// branch funct3
`define BR_BEQ   3'b000
`define BR_BNE   3'b001
`define BR_BLT   3'b100
`define BR_BGE   3'b101
`define BR_BLTU  3'b110
`define BR_BGEU  3'b111

// system funct3 where zero means ecall or mret
`define CSROP_PRIV  3'b000
`define CSROP_RW    3'b001
`define CSROP_RS    3'b010
`define CSROP_RC    3'b011

`endif
